//--- logic/cpu_pkg.sv
// ====================
// Shared types and constants for the accumulator CPU
// Imported by every design file and the testbench
// ====================
package cpu_pkg;

    localparam int WORD_W      = 8;                      // Bus and data width
    localparam int ADDR_W      = 4;                      // RAM address and PC width
    localparam int RAM_WORDS   = 16;                     // One word per address
    localparam int OUT_CREDITS = 2;                      // Credits held after reset
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1); // Counter must reach OUT_CREDITS

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Upper nibble of every instruction byte
    // Codes not listed here run as NOP
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_LDA = 4'h1,  // A <= RAM[op]
        OP_ADD = 4'h2,  // A <= A + RAM[op]
        OP_SUB = 4'h3,  // A <= A - RAM[op]
        OP_STA = 4'h4,  // RAM[op] <= A
        OP_LDI = 4'h5,  // A <= op, zero extended
        OP_JMP = 4'h6,
        OP_JC  = 4'h7,  // Jump if carry set
        OP_JZ  = 4'h8,  // Jump if zero set
        OP_OUT = 4'hE,
        OP_HLT = 4'hF
    } opcode_e;

    typedef struct packed {
        opcode_e opcode;  // Bits 7:4
        addr_t   operand; // Bits 3:0, address or immediate
    } instr_t;

    // Microsteps, T0 and T1 are the fetch
    typedef enum logic [2:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4
    } step_e;

    // Which block drives the shared bus
    typedef enum logic [2:0] {
        BUS_NONE = 3'd0,
        BUS_PC   = 3'd1,
        BUS_RAM  = 3'd2,
        BUS_IR   = 3'd3,  // Operand nibble only
        BUS_ACC  = 3'd4,
        BUS_ALU  = 3'd5
    } bus_src_e;

endpackage

//--- logic/cpu_ctrl_if.sv
// ====================
// Control word from the sequencer to the datapath blocks
// ====================
`timescale 1ns/1ns

interface cpu_ctrl_if import cpu_pkg::*; ();

    bus_src_e bus_src;   // Bus driver select
    logic     pc_inc;    // PC + 1
    logic     pc_load;   // PC <= bus[3:0]
    logic     mar_load;  // MAR <= bus[3:0]
    logic     ram_write; // RAM[MAR] <= bus
    logic     ir_load;   // IR <= bus
    logic     a_load;    // Accumulator <= bus
    logic     b_load;    // B <= bus
    logic     alu_sub;   // Subtract instead of add
    logic     alu_en;    // Latch the flags
    logic     out_load;  // Output register <= bus

    modport ctrl (
        output bus_src, pc_inc, pc_load, mar_load, ram_write, ir_load,
               a_load, b_load, alu_sub, alu_en, out_load
    );

    modport dp (
        input bus_src, pc_inc, pc_load, mar_load, ram_write, ir_load,
              a_load, b_load, alu_sub, alu_en, out_load
    );

endinterface

//--- logic/sequencer.sv
// ====================
// Microcode sequencer, steps T0..T4 and decodes the control word
// Stalls OUT without credit, parks in T2 after HLT until reset
// ====================
`timescale 1ns/1ns

module sequencer import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    input  instr_t instr,
    input  logic   carry,
    input  logic   zero,
    input  logic   has_credit,
    output logic   halted,
    cpu_ctrl_if.ctrl ctrl
);

    step_e   step;
    opcode_e op;
    logic    hold_t2; // Stay in T2 this cycle

    assign op = instr.opcode;

    // OUT waits here for a credit, HLT never leaves
    assign hold_t2 = (step == T2) &&
                     ((op == OP_HLT) || (op == OP_OUT && !has_credit));

    always_ff @(posedge clk) begin
        if (rst) begin
            step   <= T0;
            halted <= 1'b0;
        end else begin
            if (step == T2 && op == OP_HLT)
                halted <= 1'b1; // Sticky until rst
            case (step)
                T0:      if (run) step <= T1; // Idle while run is low
                T1:      step <= T2;
                T2:      if (!hold_t2) step <= T3;
                T3:      step <= T4;
                default: step <= T0;          // T4 closes the instruction
            endcase
        end
    end

    // Control word, purely from step, opcode and flags
    always_comb begin
        ctrl.bus_src   = BUS_NONE;
        ctrl.pc_inc    = 1'b0;
        ctrl.pc_load   = 1'b0;
        ctrl.mar_load  = 1'b0;
        ctrl.ram_write = 1'b0;
        ctrl.ir_load   = 1'b0;
        ctrl.a_load    = 1'b0;
        ctrl.b_load    = 1'b0;
        ctrl.alu_sub   = 1'b0;
        ctrl.alu_en    = 1'b0;
        ctrl.out_load  = 1'b0;
        if (!halted) begin
            case (step)
                T0: begin
                    if (run) begin
                        ctrl.bus_src  = BUS_PC; // Fetch address
                        ctrl.mar_load = 1'b1;
                    end
                end
                T1: begin
                    ctrl.bus_src = BUS_RAM;     // Fetch opcode byte
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                T2: begin
                    case (op)
                        OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                            ctrl.bus_src  = BUS_IR;
                            ctrl.mar_load = 1'b1;
                        end
                        OP_LDI: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.a_load  = 1'b1;
                        end
                        OP_JMP: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = 1'b1;
                        end
                        OP_JC: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = carry; // Falls through when clear
                        end
                        OP_JZ: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = zero;
                        end
                        OP_OUT: begin
                            if (has_credit) begin
                                ctrl.bus_src  = BUS_ACC;
                                ctrl.out_load = 1'b1;
                            end
                        end
                        default: ;              // NOP, HLT
                    endcase
                end
                T3: begin
                    case (op)
                        OP_LDA: begin
                            ctrl.bus_src = BUS_RAM;
                            ctrl.a_load  = 1'b1;
                        end
                        OP_ADD, OP_SUB: begin
                            ctrl.bus_src = BUS_RAM; // Operand into B
                            ctrl.b_load  = 1'b1;
                        end
                        OP_STA: begin
                            ctrl.bus_src   = BUS_ACC;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    if (op == OP_ADD || op == OP_SUB) begin
                        ctrl.bus_src = BUS_ALU;
                        ctrl.a_load  = 1'b1;
                        ctrl.alu_en  = 1'b1;           // Flags follow the result
                        ctrl.alu_sub = (op == OP_SUB);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- logic/program_counter.sv
// ====================
// 4-bit program counter, increments in fetch and loads on jumps
// ====================
`timescale 1ns/1ns

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t bus,
    cpu_ctrl_if.dp ctrl,
    output addr_t pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;                   // Program starts at address 0
        end else if (ctrl.pc_load) begin
            pc <= bus[ADDR_W-1:0];      // Jump target from operand
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;            // 15 wraps to 0
        end
    end

endmodule

//--- logic/alu.sv
// ====================
// Adder and subtractor on A and B with latched carry and zero flags
// Flags update only on alu_en
// ====================
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t a,
    input  word_t b,
    cpu_ctrl_if.dp ctrl,
    output word_t result,
    output logic  carry,
    output logic  zero
);

    word_t           b_op; // B or its inverse
    logic [WORD_W:0] sum;  // Extra bit is the carry out

    // Subtract is A + ~B + 1
    assign b_op   = ctrl.alu_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_op} + {{WORD_W{1'b0}}, ctrl.alu_sub};
    assign result = sum[WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (ctrl.alu_en) begin
            carry <= sum[WORD_W];       // Set on SUB when no borrow
            zero  <= (result == '0);
        end
    end

endmodule

//--- logic/data_reg.sv
// ====================
// Load-enabled register of any payload type
// Holds the decoded instruction or the B operand
// ====================
`timescale 1ns/1ns

module data_reg import cpu_pkg::*; #(
    parameter type T = word_t // Payload type
) (
    input  logic clk,
    input  logic rst,
    input  logic load,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;   // Decodes as NOP for the IR
        end else if (load) begin
            q <= d;
        end
    end

endmodule

//--- logic/ram16.sv
// ====================
// Memory address register and 16-byte RAM
// Host loads the program through the prog port while run is low
// ====================
`timescale 1ns/1ns

module ram16 import cpu_pkg::*; (
    input  logic  clk,
    input  logic  run,
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  word_t prog_data,
    input  word_t bus,
    cpu_ctrl_if.dp ctrl,
    output word_t rdata
);

    word_t mem [RAM_WORDS]; // Not cleared by rst, program survives it
    addr_t mar;

    // MAR takes the low nibble of the bus
    always_ff @(posedge clk) begin
        if (ctrl.mar_load)
            mar <= bus[ADDR_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (ctrl.ram_write) begin
            mem[mar] <= bus;               // STA
        end else if (prog_we && !run) begin
            mem[prog_addr] <= prog_data;   // Host load, ignored while running
        end
    end

    // Asynchronous read from the MAR
    assign rdata = mem[mar];

endmodule

//--- logic/out_port.sv
// ====================
// Output register with credit flow control
// One valid pulse per OUT, one credit spent per pulse
// ====================
`timescale 1ns/1ns

module out_port import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t bus,
    cpu_ctrl_if.dp ctrl,
    input  logic  out_credit,
    output logic  has_credit,
    output logic  out_valid,
    output word_t out_data
);

    logic [CREDIT_W-1:0] credit_cnt; // Credits the sink still grants

    // Data only changes on out_load
    always_ff @(posedge clk) begin
        if (ctrl.out_load)
            out_data <= bus;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            credit_cnt <= CREDIT_W'(OUT_CREDITS); // Full window after reset
        end else begin
            out_valid <= ctrl.out_load;           // Pulse the cycle after capture
            case ({out_valid, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1; // Spend
                2'b01:   credit_cnt <= credit_cnt + 1'b1; // Return
                default: ;                                // Both or neither
            endcase
        end
    end

    // Next OUT is at least four cycles after a pulse, count is settled by then
    assign has_credit = (credit_cnt != '0);

endmodule

//--- logic/cpu_top.sv
// ====================
// Top level of the accumulator CPU
// Bus multiplexer, accumulator and all datapath instances
// ====================
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  run,        // Low for program load
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  word_t prog_data,
    output logic  out_valid,  // One-cycle pulse per OUT
    output word_t out_data,
    input  logic  out_credit, // One pulse returns one credit
    output logic  halted
);

    word_t  bus;
    word_t  acc;        // Accumulator
    word_t  b_val;
    word_t  alu_result;
    word_t  ram_rdata;
    instr_t instr;
    addr_t  pc;
    logic   carry;
    logic   zero;
    logic   has_credit;

    cpu_ctrl_if ctrl ();

    // Shared bus, one driver per cycle
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:  bus = {{(WORD_W-ADDR_W){1'b0}}, pc};
            BUS_RAM: bus = ram_rdata;
            BUS_IR:  bus = {{(WORD_W-ADDR_W){1'b0}}, instr.operand}; // Zero extended
            BUS_ACC: bus = acc;
            BUS_ALU: bus = alu_result;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            acc <= '0;
        else if (ctrl.a_load)
            acc <= bus;
    end

    sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .instr      (instr),
        .carry      (carry),
        .zero       (zero),
        .has_credit (has_credit),
        .halted     (halted),
        .ctrl       (ctrl.ctrl)
    );

    program_counter u_pc (
        .clk  (clk),
        .rst  (rst),
        .bus  (bus),
        .ctrl (ctrl.dp),
        .pc   (pc)
    );

    alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .a      (acc),
        .b      (b_val),
        .ctrl   (ctrl.dp),
        .result (alu_result),
        .carry  (carry),
        .zero   (zero)
    );

    // Instruction register holds the decoded struct
    data_reg #(.T(instr_t)) ir (
        .clk  (clk),
        .rst  (rst),
        .load (ctrl.ir_load),
        .d    (instr_t'(bus)),
        .q    (instr)
    );

    data_reg #(.T(word_t)) b_reg (
        .clk  (clk),
        .rst  (rst),
        .load (ctrl.b_load),
        .d    (bus),
        .q    (b_val)
    );

    ram16 u_ram (
        .clk       (clk),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .bus       (bus),
        .ctrl      (ctrl.dp),
        .rdata     (ram_rdata)
    );

    out_port u_out (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus),
        .ctrl       (ctrl.dp),
        .out_credit (out_credit),
        .has_credit (has_credit),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

//--- sim/cpu_asserts.sv
// ====================
// Concurrent checks on the output credits and the halt state
// Bound into cpu_top from the testbench
// ====================
`timescale 1ns/1ns

module cpu_asserts import cpu_pkg::*; (
    input logic                clk,
    input logic                rst,
    input logic                out_valid,
    input logic                halted,
    input logic [CREDIT_W-1:0] credit_cnt  // Counter inside out_port
);

    // Each OUT gives exactly one pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else $error("out_valid held high for two cycles");

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= OUT_CREDITS)  // Sink never over-returns
        else $error("credit count above the reset value");

    // A pulse needs a credit to spend
    a_valid_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (credit_cnt != '0))
        else $error("out_valid sent with no credit left");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted)  // Only rst clears it
        else $error("halted dropped without reset");

endmodule

//--- sim/cpu_tb.sv
// ====================
// Testbench for cpu_top that loads programs over the prog port and runs them
// Every OUT value is compared with a reference model
// A credit sink returns credits after a random delay
// ====================
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    logic   clk;
    logic   rst;
    logic   run;
    logic   prog_we;
    addr_t  prog_addr;
    word_t  prog_data;
    logic   out_valid;
    word_t  out_data;
    logic   out_credit;
    logic   halted;

    word_t  prog [RAM_WORDS]; // Image for the next load
    word_t  exp_q [$];        // Model OUT sequence
    int     exp_n;
    bit     exp_halt;
    int     got_cnt;          // Values seen by the monitor
    int     owed;             // Credits the sink still holds
    int     wait_cnt;         // Cycles until the next credit pulse
    int     credit_min;       // Raised for the slow sink
    integer seed;

    cpu_top DUT (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit),
        .halted     (halted)
    );

    bind cpu_top cpu_asserts u_asserts (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .halted     (halted),
        .credit_cnt (u_out.credit_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        string line;
        if (expected !== actual) begin
            line = $sformatf("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                             $time, name, expected, actual);
            abort(line);
        end
    endtask

    // Instruction-level model of the ISA with one loop pass per instruction
    function automatic void ref_run(input word_t image [RAM_WORDS], output word_t outs [$],
                                    output int n_out, output bit halt);
        word_t      mem [RAM_WORDS];
        word_t      acc;
        logic [8:0] sum;  // Bit 8 is the carry out
        logic       c;
        logic       z;
        addr_t      pc;
        instr_t     ins;
        mem  = image;
        acc  = '0;
        c    = 1'b0;
        z    = 1'b0;
        pc   = '0;
        halt = 1'b0;
        outs.delete();
        for (int i = 0; i < 1000 && !halt; i++) begin  // Bound for runaway programs
            ins = instr_t'(mem[pc]);
            pc  = pc + 1'b1;  // Wraps after 15
            case (ins.opcode)
                OP_LDA: acc = mem[ins.operand];
                OP_ADD: begin
                    sum = {1'b0, acc} + {1'b0, mem[ins.operand]};
                    acc = sum[7:0];
                    c   = sum[8];
                    z   = (acc == 8'h00);
                end
                OP_SUB: begin
                    c   = (acc >= mem[ins.operand]);  // Carry means no borrow
                    acc = acc - mem[ins.operand];
                    z   = (acc == 8'h00);
                end
                OP_STA: mem[ins.operand] = acc;
                OP_LDI: acc = {4'h0, ins.operand};
                OP_JMP: pc = ins.operand;
                OP_JC:  if (c) pc = ins.operand;
                OP_JZ:  if (z) pc = ins.operand;
                OP_OUT: outs.push_back(acc);
                OP_HLT: halt = 1'b1;
                default: ;  // Unused codes act as NOP
            endcase
        end
        n_out = outs.size();
    endfunction

    function automatic int credit_delay();
        return credit_min + ({$random(seed)} % (21 - credit_min));
    endfunction

    // Compare each pulse in order
    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (got_cnt >= exp_q.size())
                abort("More OUT values arrived than the program produces");
            else begin
                check("out_data", exp_q[got_cnt], out_data);
                got_cnt++;
            end
        end
    end

    // Credit sink returns one pulse per received value after a random delay
    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (rst) begin
            owed     = 0;
            wait_cnt = 0;
        end else begin
            if (out_valid) begin
                if (owed == 0)
                    wait_cnt = credit_delay();
                owed++;
            end
            if (owed > 0) begin
                if (wait_cnt == 0) begin
                    out_credit <= 1'b1;
                    owed--;
                    wait_cnt = credit_delay();
                end else
                    wait_cnt--;
            end
        end
    end

    // Unused words become HLT with the address as operand
    task automatic fill_halts();
        for (int i = 0; i < RAM_WORDS; i++)
            prog[i] = {OP_HLT, 4'(i)};
    endtask

    task automatic load_program();
        for (int i = 0; i < RAM_WORDS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= addr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic reset_cpu();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program(input string name, input bit load_first);
        int n;
        ref_run(prog, exp_q, exp_n, exp_halt);
        if (!exp_halt)
            abort({"Reference model never reached HLT in ", name});
        got_cnt = 0;
        @(posedge clk);
        run <= 1'b0;
        if (load_first) begin  // Program must survive the reset
            load_program();
            reset_cpu();
        end else begin
            reset_cpu();
            load_program();
        end
        @(posedge clk);
        run <= 1'b1;
        n = 0;
        while (!halted && n < 3000) begin
            @(posedge clk);
            n++;
        end
        if (!halted)
            abort({"Timed out waiting for halted in ", name});
        n = 0;
        while (got_cnt < exp_n && n < 500) begin
            @(posedge clk);
            n++;
        end
        check("out_valid count", exp_n, got_cnt);
        n = 0;
        while (owed != 0 && n < 500) begin  // Let the sink hand every credit back
            @(posedge clk);
            n++;
        end
        if (owed != 0)
            abort({"Credit sink did not drain in ", name});
        repeat (50) begin
            @(posedge clk);
            check("halted", 1, halted);
            check("out_valid", 0, out_valid);
        end
        $display("%s: %0d values matched", name, exp_n);
    endtask

    // Watchdog on top of the per-wait limits
    initial begin
        repeat (100000) @(posedge clk);
        abort("Simulation ran past its cycle limit");
    end

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        out_credit = 1'b0;
        got_cnt    = 0;
        credit_min = 0;
        seed       = 32'h1d00_8d5c;

        fill_halts();                 // Arithmetic with wrap, result through RAM
        prog[0]  = {OP_LDA, 4'hC};
        prog[1]  = {OP_ADD, 4'hD};
        prog[2]  = {OP_SUB, 4'hE};
        prog[3]  = {OP_STA, 4'hF};
        prog[4]  = {OP_LDI, 4'h0};    // Clear A before reading back
        prog[5]  = {OP_LDA, 4'hF};
        prog[6]  = {OP_OUT, 4'h0};
        prog[12] = 8'hC8;
        prog[13] = 8'h5A;
        prog[14] = 8'h37;
        prog[15] = 8'h00;
        run_program("arithmetic", 1'b0);

        fill_halts();                 // Countdown from 5 to 0
        prog[0]  = {OP_LDA, 4'hE};
        prog[1]  = {OP_OUT, 4'h0};
        prog[2]  = {OP_SUB, 4'hF};
        prog[3]  = {OP_JZ,  4'h6};
        prog[4]  = {OP_JC,  4'h1};    // Carry set while no borrow
        prog[6]  = {OP_OUT, 4'h0};
        prog[7]  = {OP_JMP, 4'h9};
        prog[14] = 8'h05;
        prog[15] = 8'h01;
        run_program("countdown", 1'b0);

        fill_halts();                 // Eight OUTs in a row against a slow sink
        prog[0]  = {OP_LDA, 4'hF};
        for (int i = 1; i <= 8; i++)
            prog[i] = {OP_OUT, 4'h0};
        prog[15] = 8'hA5;
        credit_min = 12;
        run_program("back-pressure", 1'b0);
        credit_min = 0;

        fill_halts();                 // New program loaded before the reset
        prog[0]  = {OP_LDI, 4'h3};
        prog[1]  = {OP_OUT, 4'h0};
        prog[2]  = {OP_LDI, 4'hC};
        prog[3]  = {OP_OUT, 4'h0};
        prog[4]  = {OP_LDI, 4'h7};
        prog[5]  = {OP_OUT, 4'h0};
        run_program("reload", 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- list.f
logic/cpu_pkg.sv
logic/cpu_ctrl_if.sv
logic/sequencer.sv
logic/program_counter.sv
logic/alu.sv
logic/data_reg.sv
logic/ram16.sv
logic/out_port.sv
logic/cpu_top.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv
